// File: Makefile
# Verilator build and run of the I/O hub testbench
VERILATOR ?= verilator
TOP       ?= tb_io_hub
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench, fail unless it passes"
	@echo "make clean  remove the build directory"
	@echo "variables:  VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf $(BUILD_DIR)

// File: cmd_issuer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Display command queue drained by a
// four-phase req/ack master
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cmd_issuer import io_pkg::*; (
    input  wire logic       clk_cpu,
    input  wire logic       rst_n,
    input  wire io_access_t access_i,
    output      logic       cmd_ready_o,
    output      logic       cmd_req_o,
    input  wire logic       cmd_ack_i,
    output      cmd_word_t  cmd_data_o
);

    logic push;
    logic pop;
    logic empty;
    logic full;

    assign push = access_i.valid && access_i.write && (access_i.reg_idx == REG_CMD);
    assign pop  = cmd_req_o && cmd_ack_i;   // word taken by the engine

    sync_fifo #(
        .payload_t  (cmd_word_t),
        .DEPTH_LOG2 (CMD_DEPTH_LOG2)
    ) fifo0 (
        .clk_cpu (clk_cpu),
        .rst_n   (rst_n),
        .push_i  (push),
        .data_i  (access_i.wdata),
        .pop_i   (pop),
        .head_o  (cmd_data_o),
        .empty_o (empty),
        .full_o  (full)
    );

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            cmd_req_o <= 1'b0;
        end else if (cmd_req_o) begin
            if (cmd_ack_i) begin
                cmd_req_o <= 1'b0;
            end
        end else if (!empty && !cmd_ack_i) begin
            cmd_req_o <= 1'b1;      // previous ack must be gone first
        end
    end

    assign cmd_ready_o = !full;

endmodule

`default_nettype wire

// File: io_control.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four-phase bus slave: access decode
// and the LED register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module io_control import io_pkg::*; (
    input  wire logic       clk_cpu,
    input  wire logic       rst_n,
    input  wire logic       bus_req_i,
    input  wire io_req_t    bus_i,
    output      logic       bus_ack_o,
    output      io_access_t access_o,
    output      logic [7:0] led_o
);

    typedef enum logic {
        ST_IDLE,
        ST_ACK
    } ack_state_t;

    ack_state_t state_q;
    logic       start;

    // new transaction: req seen while not yet acknowledged
    assign start = bus_req_i && (state_q == ST_IDLE);

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (bus_req_i) begin
                        state_q <= ST_ACK;      // ack one cycle after req
                    end
                end
                ST_ACK: begin
                    if (!bus_req_i) begin
                        state_q <= ST_IDLE;     // drop ack after req low
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    assign bus_ack_o = (state_q == ST_ACK);

    // single pulse, side effects land on the edge that raises ack
    assign access_o.valid   = start;
    assign access_o.write   = bus_i.write;
    assign access_o.reg_idx = bus_i.reg_idx;
    assign access_o.wdata   = bus_i.wdata;

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            led_o <= 8'd0;
        end else if (start && bus_i.write && (bus_i.reg_idx == REG_LED)) begin
            led_o <= bus_i.wdata[7:0];    // low byte only
        end
    end

endmodule

`default_nettype wire

// File: io_hub_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I/O hub top level: bus slave, timer,
// receive channels, command issuer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module io_hub_top import io_pkg::*; (
    input  wire logic                     clk_cpu,
    input  wire logic                     rst_n,
    // external bus, hub is slave
    input  wire logic                     bus_req_i,
    input  wire io_req_t                  bus_i,
    output      logic                     bus_ack_o,
    output      logic [DATA_W-1:0]        bus_rdata_o,
    // receive sources
    input  wire logic [NUM_RX_CH-1:0]     rx_valid_i,
    input  wire rx_byte_t [NUM_RX_CH-1:0] rx_data_i,
    output      logic [7:0]               led_o,
    // drawing engine command port
    output      logic                     cmd_req_o,
    input  wire logic                     cmd_ack_i,
    output      cmd_word_t                cmd_data_o
);

    io_access_t                access;
    logic [DATA_W-1:0]         ms_count;
    rx_byte_t [NUM_RX_CH-1:0]  rx_head;
    rx_stat_t [NUM_RX_CH-1:0]  rx_stat;
    logic                      cmd_ready;

    io_control ctrl0 (
        .clk_cpu   (clk_cpu),
        .rst_n     (rst_n),
        .bus_req_i (bus_req_i),
        .bus_i     (bus_i),
        .bus_ack_o (bus_ack_o),
        .access_o  (access),
        .led_o     (led_o)
    );

    ms_timer timer0 (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .ms_count_o (ms_count)
    );

    for (genvar k = 0; k < NUM_RX_CH; k++) begin : g_rx
        rx_channel #(
            .CH_INDEX (k)
        ) chan (
            .clk_cpu    (clk_cpu),
            .rst_n      (rst_n),
            .access_i   (access),
            .rx_valid_i (rx_valid_i[k]),
            .rx_data_i  (rx_data_i[k]),
            .head_o     (rx_head[k]),
            .stat_o     (rx_stat[k])
        );
    end

    cmd_issuer cmd0 (
        .clk_cpu     (clk_cpu),
        .rst_n       (rst_n),
        .access_i    (access),
        .cmd_ready_o (cmd_ready),
        .cmd_req_o   (cmd_req_o),
        .cmd_ack_i   (cmd_ack_i),
        .cmd_data_o  (cmd_data_o)
    );

    io_read_mux rmux0 (
        .clk_cpu     (clk_cpu),
        .rst_n       (rst_n),
        .access_i    (access),
        .ms_count_i  (ms_count),
        .rx_head_i   (rx_head),
        .rx_stat_i   (rx_stat),
        .cmd_ready_i (cmd_ready),
        .bus_rdata_o (bus_rdata_o)
    );

endmodule

`default_nettype wire

// File: io_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I/O hub shared definitions: register
// map, sizes, display geometry, bus types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package io_pkg;

    localparam int CLK_HZ         = 25_000_000;
    localparam int CYCLES_PER_MS  = CLK_HZ / 1000;
    localparam int MS_CNT_W       = 17;        // divider width, holds CYCLES_PER_MS
    localparam int DATA_W         = 32;
    localparam int REG_ADDR_W     = 4;
    localparam int NUM_RX_CH      = 2;
    localparam int RX_DEPTH_LOG2  = 4;         // 16 bytes per channel
    localparam int CMD_DEPTH_LOG2 = 2;         // 4 command words

    // register map, word indices
    localparam logic [REG_ADDR_W-1:0] REG_MS      = 4'd0;
    localparam logic [REG_ADDR_W-1:0] REG_LED     = 4'd1;
    localparam logic [REG_ADDR_W-1:0] REG_RX_BASE = 4'd2;  // data at +2k, status at +2k+1
    localparam logic [REG_ADDR_W-1:0] REG_CMD     = 4'd8;
    localparam logic [REG_ADDR_W-1:0] REG_GEOM    = 4'd9;

    localparam int H_RES = 640;
    localparam int V_RES = 480;

    typedef logic [7:0]        rx_byte_t;
    typedef logic [DATA_W-1:0] cmd_word_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] reg_idx;
        logic                  write;
        logic [DATA_W-1:0]     wdata;
    } io_req_t;

    // one-cycle decoded access
    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [REG_ADDR_W-1:0] reg_idx;
        logic [DATA_W-1:0]     wdata;
    } io_access_t;

    typedef struct packed {
        logic not_empty;  // bit 1 of status reg
        logic overflow;   // bit 0, sticky
    } rx_stat_t;

endpackage

`default_nettype wire

// File: io_read_mux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read data select and register for the
// current bus access
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module io_read_mux import io_pkg::*; (
    input  wire logic                           clk_cpu,
    input  wire logic                           rst_n,
    input  wire io_access_t                     access_i,
    input  wire logic [DATA_W-1:0]              ms_count_i,
    input  wire rx_byte_t [NUM_RX_CH-1:0]       rx_head_i,
    input  wire rx_stat_t [NUM_RX_CH-1:0]       rx_stat_i,
    input  wire logic                           cmd_ready_i,
    output      logic [DATA_W-1:0]              bus_rdata_o
);

    logic [DATA_W-1:0] rd_sel;

    always_comb begin
        rd_sel = '0;    // LED and unmapped regs read zero
        case (access_i.reg_idx)
            REG_MS:   rd_sel = ms_count_i;
            REG_CMD:  rd_sel = DATA_W'(cmd_ready_i);
            REG_GEOM: rd_sel = {16'(H_RES), 16'(V_RES)};
            default:  rd_sel = '0;
        endcase
        for (int k = 0; k < NUM_RX_CH; k++) begin
            if (access_i.reg_idx == REG_RX_BASE + REG_ADDR_W'(2 * k)) begin
                // stale head of an empty queue is masked
                rd_sel = rx_stat_i[k].not_empty ? DATA_W'(rx_head_i[k]) : '0;
            end
            if (access_i.reg_idx == REG_RX_BASE + REG_ADDR_W'(2 * k + 1)) begin
                rd_sel = DATA_W'(rx_stat_i[k]);   // not_empty, overflow
            end
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            bus_rdata_o <= '0;
        end else if (access_i.valid && !access_i.write) begin
            bus_rdata_o <= rd_sel;      // captured with ack rise
        end
    end

endmodule

`default_nettype wire

// File: ms_timer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Millisecond tick divider and counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ms_timer import io_pkg::*; (
    input  wire logic              clk_cpu,
    input  wire logic              rst_n,
    output      logic [DATA_W-1:0] ms_count_o
);

    logic [MS_CNT_W-1:0] div_q;
    logic                tick;

    assign tick = (div_q == MS_CNT_W'(CYCLES_PER_MS - 1));

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            div_q      <= '0;
            ms_count_o <= '0;
        end else begin
            div_q <= tick ? '0 : div_q + 1'b1;   // wrap every ms
            if (tick) begin
                ms_count_o <= ms_count_o + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rx_channel.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Receive-byte channel: byte queue with
// a sticky overflow flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module rx_channel import io_pkg::*; #(
    parameter int CH_INDEX = 0
) (
    input  wire logic       clk_cpu,
    input  wire logic       rst_n,
    input  wire io_access_t access_i,
    input  wire logic       rx_valid_i,
    input  wire rx_byte_t   rx_data_i,
    output      rx_byte_t   head_o,
    output      rx_stat_t   stat_o
);

    localparam logic [REG_ADDR_W-1:0] DATA_REG = REG_RX_BASE + REG_ADDR_W'(2 * CH_INDEX);
    localparam logic [REG_ADDR_W-1:0] STAT_REG = DATA_REG + 1'b1;

    logic rd_data;
    logic rd_stat;
    logic empty;
    logic full;
    logic overflow_q;

    assign rd_data = access_i.valid && !access_i.write && (access_i.reg_idx == DATA_REG);
    assign rd_stat = access_i.valid && !access_i.write && (access_i.reg_idx == STAT_REG);

    sync_fifo #(
        .payload_t  (rx_byte_t),
        .DEPTH_LOG2 (RX_DEPTH_LOG2)
    ) fifo0 (
        .clk_cpu (clk_cpu),
        .rst_n   (rst_n),
        .push_i  (rx_valid_i),
        .data_i  (rx_data_i),
        .pop_i   (rd_data),     // data read pops
        .head_o  (head_o),
        .empty_o (empty),
        .full_o  (full)
    );

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            overflow_q <= 1'b0;
        end else if (rx_valid_i && full) begin
            overflow_q <= 1'b1;     // new loss wins over a clearing read
        end else if (rd_stat) begin
            overflow_q <= 1'b0;
        end
    end

    assign stat_o.not_empty = !empty;
    assign stat_o.overflow  = overflow_q;

endmodule

`default_nettype wire

// File: sim.f
io_pkg.sv
sync_fifo.sv
rx_channel.sv
io_control.sv
ms_timer.sv
cmd_issuer.sv
io_read_mux.sv
io_hub_top.sv
tb_io_hub.sv

// File: sync_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-clock FIFO, payload set by a
// type parameter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter type payload_t  = logic [7:0],
    parameter int  DEPTH_LOG2 = 4
) (
    input  wire logic     clk_cpu,
    input  wire logic     rst_n,
    input  wire logic     push_i,
    input  wire payload_t data_i,
    input  wire logic     pop_i,
    output      payload_t head_o,
    output      logic     empty_o,
    output      logic     full_o
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    payload_t              mem_q [DEPTH];
    logic [DEPTH_LOG2:0]   wr_ptr_q;  // extra msb tells full from empty
    logic [DEPTH_LOG2:0]   rd_ptr_q;
    logic                  do_push;
    logic                  do_pop;

    assign empty_o = (wr_ptr_q == rd_ptr_q);
    assign full_o  = (wr_ptr_q[DEPTH_LOG2] != rd_ptr_q[DEPTH_LOG2]) &&
                     (wr_ptr_q[DEPTH_LOG2-1:0] == rd_ptr_q[DEPTH_LOG2-1:0]);

    assign do_push = push_i && !full_o;   // dropped when full
    assign do_pop  = pop_i && !empty_o;

    assign head_o = mem_q[rd_ptr_q[DEPTH_LOG2-1:0]];

    always_ff @(posedge clk_cpu) begin
        if (do_push) begin
            mem_q[wr_ptr_q[DEPTH_LOG2-1:0]] <= data_i;
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_io_hub.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I/O hub testbench covering the bus slave,
// receive channels, command port and timer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_io_hub import io_pkg::*; ();

    localparam int WAIT_LIMIT = 100;    // cycles per handshake wait
    localparam int ACK_LAG    = 2;      // extra cycles ack stays up after req falls

    logic                     clk_cpu = 1'b0;
    logic                     rst_n;
    logic                     bus_req;
    io_req_t                  bus;
    logic                     bus_ack;
    logic [31:0]              bus_rdata;
    logic [NUM_RX_CH-1:0]     rx_valid;
    rx_byte_t [NUM_RX_CH-1:0] rx_data;
    logic [7:0]               led;
    logic                     cmd_req;
    logic                     cmd_ack;
    cmd_word_t                cmd_data;

    int          errors = 0;
    int          checks = 0;
    integer      seed = 61035;
    logic        hold_ack;              // engine withholds ack
    logic        req_seen;              // cmd_req at previous sample
    int          ack_delay = 0;         // cycles req has been seen low with ack up
    cmd_word_t   got_cmds[$];
    rx_byte_t    exp_mem[NUM_RX_CH][16];
    logic [31:0] rd;

    always #5 clk_cpu = ~clk_cpu;

    io_hub_top dut0 (
        .clk_cpu     (clk_cpu),
        .rst_n       (rst_n),
        .bus_req_i   (bus_req),
        .bus_i       (bus),
        .bus_ack_o   (bus_ack),
        .bus_rdata_o (bus_rdata),
        .rx_valid_i  (rx_valid),
        .rx_data_i   (rx_data),
        .led_o       (led),
        .cmd_req_o   (cmd_req),
        .cmd_ack_i   (cmd_ack),
        .cmd_data_o  (cmd_data)
    );

    task automatic next_cycle;
        @(posedge clk_cpu);
        #1;                             // drive and sample after the edge
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic bus_transfer(input logic [3:0] idx, input logic wr,
                                input logic [31:0] wd, output logic [31:0] rdata);
        int n;
        bus     = '{reg_idx: idx, write: wr, wdata: wd};
        bus_req = 1'b1;
        n = 0;
        do begin
            next_cycle();
            n++;
        end while (!bus_ack && n < WAIT_LIMIT);
        if (!bus_ack) begin
            $display("timeout: bus ack never rose for register %0d", idx);
            errors++;
        end
        check_value("ack latency", 1, n);
        rdata   = bus_rdata;            // valid while ack is high
        bus_req = 1'b0;
        n = 0;
        do begin
            next_cycle();
            n++;
        end while (bus_ack && n < WAIT_LIMIT);
        if (bus_ack) begin
            $display("timeout: bus ack stayed high after request dropped");
            errors++;
        end
    endtask

    task automatic bus_write(input logic [3:0] idx, input logic [31:0] wd);
        logic [31:0] discard;
        bus_transfer(idx, 1'b1, wd, discard);
    endtask

    task automatic bus_read(input logic [3:0] idx, output logic [31:0] rdata);
        bus_transfer(idx, 1'b0, 32'd0, rdata);
    endtask

    task automatic read_expect(input string name, input logic [3:0] idx,
                               input logic [31:0] expected);
        logic [31:0] value;
        bus_read(idx, value);
        check_value(name, expected, value);
    endtask

    // random bytes into the masked channels with the first 16 remembered
    task automatic push_bytes(input logic [NUM_RX_CH-1:0] mask, input int count);
        for (int i = 0; i < count; i++) begin
            for (int k = 0; k < NUM_RX_CH; k++) begin
                rx_data[k] = 8'($random(seed));
                if (mask[k] && i < 16) begin
                    exp_mem[k][i] = rx_data[k];
                end
            end
            rx_valid = mask;
            next_cycle();
        end
        rx_valid = '0;
    endtask

    task automatic drain_channel(input int k, input int count);
        for (int i = 0; i < count; i++) begin
            read_expect("rx status busy", 4'(3 + 2 * k), 32'd2);
            read_expect("rx data order", 4'(2 + 2 * k), 32'(exp_mem[k][i]));
        end
        read_expect("rx status empty", 4'(3 + 2 * k), 32'd0);
        read_expect("rx data empty", 4'(2 + 2 * k), 32'd0);
    endtask

    task automatic wait_cmds(input int count);
        int n;
        n = 0;
        while (got_cmds.size() < count && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (got_cmds.size() < count) begin
            $display("timeout: only %0d of %0d command words arrived", got_cmds.size(), count);
            errors++;
        end
    endtask

    // drawing engine as a four-phase receiver whose ack lingers after req falls
    always begin
        next_cycle();
        if (rst_n) begin
            if (cmd_req && !req_seen) begin
                assert (!cmd_ack) else begin
                    $display("cmd_req rose while cmd_ack was still high");
                    errors++;
                end
            end
            if (cmd_req && !cmd_ack && !hold_ack) begin
                got_cmds.push_back(cmd_data);
                cmd_ack   = 1'b1;
                ack_delay = 0;
            end else if (!cmd_req && cmd_ack) begin
                if (ack_delay >= ACK_LAG) begin
                    cmd_ack = 1'b0;
                end else begin
                    ack_delay++;
                end
            end
        end
        req_seen = cmd_req;
    end

    initial begin
        rst_n    = 1'b0;
        bus_req  = 1'b0;
        bus      = '0;
        rx_valid = '0;
        rx_data  = '0;
        cmd_ack  = 1'b0;
        hold_ack = 1'b0;
        req_seen = 1'b0;
        repeat (8) next_cycle();
        rst_n = 1'b1;
        next_cycle();

        check_value("ack after reset", 0, bus_ack);
        check_value("cmd_req after reset", 0, cmd_req);
        check_value("led after reset", 0, led);
        read_expect("ms after reset", REG_MS, 0);
        bus_write(REG_LED, 32'h1234_56A5);
        check_value("led load", 32'hA5, led);
        read_expect("led reads zero", REG_LED, 0);
        read_expect("geometry", REG_GEOM, {16'd640, 16'd480});

        // both channels at once and then each drained on its own
        push_bytes(2'b11, 10);
        drain_channel(0, 10);
        drain_channel(1, 10);

        push_bytes(2'b10, 17);          // one past the queue depth
        read_expect("overflow set", 4'd5, 32'd3);
        read_expect("overflow cleared", 4'd5, 32'd2);
        drain_channel(1, 16);

        read_expect("cmd ready idle", REG_CMD, 1);
        got_cmds.delete();
        for (int i = 0; i < 3; i++) begin
            bus_write(REG_CMD, 32'hC0DE_0000 + i);
        end
        wait_cmds(3);
        for (int i = 0; i < 3; i++) begin
            check_value("cmd order", 32'hC0DE_0000 + i, got_cmds[i]);
        end

        hold_ack = 1'b1;
        got_cmds.delete();
        for (int i = 0; i < 4; i++) begin
            bus_write(REG_CMD, 32'hA5A5_0000 + i);
        end
        read_expect("cmd ready full", REG_CMD, 0);
        bus_write(REG_CMD, 32'hDEAD_BEEF);  // queue full so this word is dropped
        hold_ack = 1'b0;
        wait_cmds(4);
        repeat (20) next_cycle();           // quiet period in which nothing more may arrive
        check_value("cmd count", 4, got_cmds.size());
        for (int i = 0; i < 4; i++) begin
            check_value("cmd order full", 32'hA5A5_0000 + i, got_cmds[i]);
        end
        read_expect("cmd ready drained", REG_CMD, 1);

        repeat (30000) next_cycle();
        bus_read(REG_MS, rd);
        checks++;
        assert (rd >= 1 && rd <= 2) else begin
            $display("[FAIL] ms after wait: expected 1 to 2, actual %0d", rd);
            errors++;
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
